//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST)) hw/cpu_params.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
+incdir+hw
hw/cpu_pkg.sv
hw/cpu_regfile.sv
hw/cpu_decode.sv
hw/cpu_execute.sv
hw/cpu_result.sv
hw/cpu_top.sv
tb/cpu_asserts.sv
tb/cpu_tb.sv

//--- hw/cpu_decode.sv
`include "cpu_params.svh"

module cpu_decode
(
    input  logic                 clk,
    input  logic                 arst_n,
    output logic [`CPU_XLEN-1:0] imem_addr,
    input  cpu_pkg::instr_u      imem_data,
    input  cpu_pkg::fwd_t        ex_fwd,
    input  logic                 ex_mem_read,
    input  cpu_pkg::fwd_t        mem_fwd,
    input  cpu_pkg::wb_t         wr,
    output cpu_pkg::id_ex_t      id_ex,
    output logic                 id_bubble
);

    logic [`CPU_XLEN-1:0]   pc_q;
    logic [`CPU_XLEN-1:0]   pc4_q;      // pc+4 of the fetched word
    cpu_pkg::instr_u        instr_q;
    logic                   valid_q;
    logic [5:0]             opcode;
    logic [`CPU_RIDX_W-1:0] rs;
    logic [`CPU_RIDX_W-1:0] rt;
    logic                   is_rtype;
    logic                   is_beq;
    logic                   is_j;
    logic                   uses_rs;
    logic                   uses_rt;
    cpu_pkg::ctrl_t         ctrl;
    logic [`CPU_XLEN-1:0]   rs_data;
    logic [`CPU_XLEN-1:0]   rt_data;
    logic [`CPU_XLEN-1:0]   imm_sext;
    logic [`CPU_XLEN-1:0]   br_target;
    logic [`CPU_XLEN-1:0]   j_target;
    logic                   load_use;
    logic                   beq_wait;
    logic                   stall;
    logic                   redirect;

    // older instruction writes this source
    function automatic logic src_hit(input cpu_pkg::fwd_t f,
                                     input logic [`CPU_RIDX_W-1:0] idx);
        return f.reg_write && (f.dest != '0) && (f.dest == idx);
    endfunction

    //////////////////////////////////////////////////
    // field extraction and control

    assign opcode   = instr_q.r.opcode;
    assign rs       = instr_q.i.rs;
    assign rt       = instr_q.i.rt;
    assign imm_sext = {{(`CPU_XLEN-16){instr_q.i.imm[15]}}, instr_q.i.imm};

    assign is_rtype = (opcode == `CPU_OP_RTYPE);
    assign is_beq   = (opcode == `CPU_OP_BEQ);
    assign is_j     = (opcode == `CPU_OP_J);
    assign uses_rs  = is_rtype || is_beq || (opcode == `CPU_OP_LW)
                   || (opcode == `CPU_OP_SW) || (opcode == `CPU_OP_ADDI);
    assign uses_rt  = is_rtype || is_beq || (opcode == `CPU_OP_SW);

    always_comb
    begin
        ctrl = '0;
        case (opcode)
            `CPU_OP_RTYPE:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_class = cpu_pkg::cls_funct;
            end
            `CPU_OP_LW:
            begin
                ctrl.use_imm    = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            `CPU_OP_SW:
            begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            `CPU_OP_BEQ:  ctrl.alu_class = cpu_pkg::cls_branch;
            `CPU_OP_ADDI:
            begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default:      ctrl = '0; // j and unknown opcodes are no-ops
        endcase
    end

    cpu_regfile u_regfile
    (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs      (rs),
        .rt      (rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr      (wr)
    );

    //////////////////////////////////////////////////
    // hazards and redirect

    assign load_use = ex_mem_read && ((uses_rs && src_hit(ex_fwd, rs))
                                   || (uses_rt && src_hit(ex_fwd, rt)));
    // beq compares here, so wait until producers reach write-back
    assign beq_wait = is_beq && (src_hit(ex_fwd, rs) || src_hit(ex_fwd, rt)
                              || src_hit(mem_fwd, rs) || src_hit(mem_fwd, rt));
    assign stall    = valid_q && (load_use || beq_wait);

    assign br_target = pc4_q + {imm_sext[`CPU_XLEN-3:0], 2'b00};
    assign j_target  = {pc4_q[`CPU_XLEN-1:`CPU_XLEN-4], instr_q.j.target, 2'b00};
    assign redirect  = valid_q && !stall && (is_j || (is_beq && (rs_data == rt_data)));

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc_q    <= '0;
            valid_q <= 1'b0;
        end
        else if (!stall)
        begin
            if (redirect)
                pc_q <= is_j ? j_target : br_target;
            else
                pc_q <= pc_q + 'd4;
            valid_q <= !redirect; // drop the wrong-path fetch
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            instr_q <= imem_data;
            pc4_q   <= pc_q + 'd4;
        end
    end

    assign imem_addr = pc_q;
    assign id_bubble = !valid_q || stall;
    assign id_ex     = '{ctrl:   ctrl,
                         rs:     rs,
                         rt:     rt,
                         dest:   is_rtype ? instr_q.r.rd : rt,
                         rs_val: rs_data,
                         rt_val: rt_data,
                         imm:    imm_sext,
                         funct:  instr_q.r.funct};

endmodule

//--- hw/cpu_execute.sv
`include "cpu_params.svh"

module cpu_execute
(
    input  logic              clk,
    input  logic              arst_n,
    input  cpu_pkg::id_ex_t   id_ex,
    input  logic              id_bubble,
    input  cpu_pkg::wb_t      wb,
    output cpu_pkg::ex_mem_t  ex_mem,
    output cpu_pkg::fwd_t     ex_fwd,
    output logic              ex_mem_read,
    output cpu_pkg::fwd_t     mem_fwd
);

    cpu_pkg::id_ex_t      ex_q;
    cpu_pkg::ex_mem_t     mem_q;
    cpu_pkg::alu_op_e     alu_op;
    logic [`CPU_XLEN-1:0] op_a;
    logic [`CPU_XLEN-1:0] rt_fwd;
    logic [`CPU_XLEN-1:0] op_b;
    logic [`CPU_XLEN-1:0] alu_y;

    // one operand, memory stage wins over write-back
    function automatic logic [`CPU_XLEN-1:0] fwd_operand(
        input logic [`CPU_RIDX_W-1:0] idx,
        input logic [`CPU_XLEN-1:0]   reg_val,
        input cpu_pkg::ex_mem_t       mem,
        input cpu_pkg::wb_t           wbk);
        if (mem.reg_write && (mem.dest != '0) && (mem.dest == idx))
            return mem.alu_result;
        else if (wbk.valid && (wbk.dest != '0) && (wbk.dest == idx))
            return wbk.data;
        else
            return reg_val;
    endfunction

    //////////////////////////////////////////////////
    // decode to execute register

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ex_q <= '0;
        end
        else
        begin
            ex_q <= id_ex;
            if (id_bubble)
                ex_q.ctrl <= '0; // bubble, no side effects
        end
    end

    assign op_a   = fwd_operand(ex_q.rs, ex_q.rs_val, mem_q, wb);
    assign rt_fwd = fwd_operand(ex_q.rt, ex_q.rt_val, mem_q, wb);
    assign op_b   = ex_q.ctrl.use_imm ? ex_q.imm : rt_fwd;

    always_comb
    begin
        case (ex_q.ctrl.alu_class)
            cpu_pkg::cls_mem:    alu_op = cpu_pkg::alu_add;
            cpu_pkg::cls_branch: alu_op = cpu_pkg::alu_sub;
            cpu_pkg::cls_funct:
            begin
                case (ex_q.funct)
                    `CPU_FN_ADD: alu_op = cpu_pkg::alu_add;
                    `CPU_FN_SUB: alu_op = cpu_pkg::alu_sub;
                    `CPU_FN_AND: alu_op = cpu_pkg::alu_and;
                    `CPU_FN_OR:  alu_op = cpu_pkg::alu_or;
                    `CPU_FN_SLT: alu_op = cpu_pkg::alu_slt;
                    default:     alu_op = cpu_pkg::alu_none;
                endcase
            end
            default:             alu_op = cpu_pkg::alu_none;
        endcase
    end

    always_comb
    begin
        case (alu_op)
            cpu_pkg::alu_and: alu_y = op_a & op_b;
            cpu_pkg::alu_or:  alu_y = op_a | op_b;
            cpu_pkg::alu_add: alu_y = op_a + op_b;
            cpu_pkg::alu_sub: alu_y = op_a - op_b;
            cpu_pkg::alu_slt: alu_y = ($signed(op_a) < $signed(op_b)) ? 'd1 : '0;
            default:          alu_y = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // execute to memory register

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            mem_q <= '0;
        else
            mem_q <= '{mem_read:   ex_q.ctrl.mem_read,
                       mem_write:  ex_q.ctrl.mem_write,
                       reg_write:  ex_q.ctrl.reg_write,
                       mem_to_reg: ex_q.ctrl.mem_to_reg,
                       dest:       ex_q.dest,
                       alu_result: alu_y,
                       store_data: rt_fwd};
    end

    assign ex_mem      = mem_q;
    assign ex_fwd      = '{reg_write: ex_q.ctrl.reg_write, dest: ex_q.dest};
    assign ex_mem_read = ex_q.ctrl.mem_read;
    assign mem_fwd     = '{reg_write: mem_q.reg_write, dest: mem_q.dest};

endmodule

//--- hw/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath and register file sizes
`define CPU_XLEN        32
`define CPU_NREGS       32
`define CPU_RIDX_W      5

// data memory depth in words, byte address bits [1:0] ignored
`define CPU_DMEM_WORDS  32

// primary opcodes
`define CPU_OP_RTYPE    6'b000000
`define CPU_OP_LW       6'b100011
`define CPU_OP_SW       6'b101011
`define CPU_OP_BEQ      6'b000100
`define CPU_OP_ADDI     6'b001000
`define CPU_OP_J        6'b000010

// r-type function field
`define CPU_FN_ADD      6'b100000
`define CPU_FN_SUB      6'b100010
`define CPU_FN_AND      6'b100100
`define CPU_FN_OR       6'b100101
`define CPU_FN_SLT      6'b101010

`endif

//--- hw/cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

    //////////////////////////////////////////////////
    // instruction word views

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`CPU_RIDX_W-1:0] rs;
        logic [`CPU_RIDX_W-1:0] rt;
        logic [`CPU_RIDX_W-1:0] rd;
        logic [4:0]             shamt;
        logic [5:0]             funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`CPU_RIDX_W-1:0] rs;
        logic [`CPU_RIDX_W-1:0] rt;
        logic [15:0]            imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

    //////////////////////////////////////////////////
    // alu and control encodings

    typedef enum logic [3:0] {
        alu_and  = 4'b0000,
        alu_or   = 4'b0001,
        alu_add  = 4'b0010,
        alu_sub  = 4'b0110,
        alu_slt  = 4'b0111, // signed compare
        alu_none = 4'b1111
    } alu_op_e;

    typedef enum logic [1:0] {
        cls_mem    = 2'b00, // address add, also addi
        cls_branch = 2'b01,
        cls_funct  = 2'b10  // look at funct
    } alu_class_e;

    typedef struct packed {
        logic       use_imm;
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
        logic       mem_to_reg;
        alu_class_e alu_class;
    } ctrl_t;

    //////////////////////////////////////////////////
    // stage registers

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [`CPU_RIDX_W-1:0] rs;
        logic [`CPU_RIDX_W-1:0] rt;
        logic [`CPU_RIDX_W-1:0] dest;   // rd or rt, picked in decode
        logic [`CPU_XLEN-1:0]   rs_val;
        logic [`CPU_XLEN-1:0]   rt_val;
        logic [`CPU_XLEN-1:0]   imm;    // sign extended
        logic [5:0]             funct;
    } id_ex_t;

    typedef struct packed {
        logic                   mem_read;
        logic                   mem_write;
        logic                   reg_write;
        logic                   mem_to_reg;
        logic [`CPU_RIDX_W-1:0] dest;
        logic [`CPU_XLEN-1:0]   alu_result;
        logic [`CPU_XLEN-1:0]   store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                   valid;
        logic [`CPU_RIDX_W-1:0] dest;
        logic [`CPU_XLEN-1:0]   data;
    } wb_t;

    typedef struct packed {
        logic                   reg_write;
        logic [`CPU_RIDX_W-1:0] dest;
    } fwd_t;

endpackage

//--- hw/cpu_regfile.sv
`include "cpu_params.svh"

module cpu_regfile
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`CPU_RIDX_W-1:0] rs,
    input  logic [`CPU_RIDX_W-1:0] rt,
    output logic [`CPU_XLEN-1:0]   rs_data,
    output logic [`CPU_XLEN-1:0]   rt_data,
    input  cpu_pkg::wb_t           wr
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];
    logic                 wr_en;

    assign wr_en = wr.valid && (wr.dest != '0); // r0 stays zero

    // read with bypass of a write in the same cycle
    function automatic logic [`CPU_XLEN-1:0] read_port(input logic [`CPU_RIDX_W-1:0] idx);
        if (idx == '0)
            return '0;
        else if (wr_en && (wr.dest == idx))
            return wr.data;
        else
            return regs[idx];
    endfunction

    always_comb
    begin
        rs_data = read_port(rs);
        rt_data = read_port(rt);
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int k = 0; k < `CPU_NREGS; k++)
                regs[k] <= '0;
        end
        else if (wr_en)
        begin
            regs[wr.dest] <= wr.data;
        end
    end

endmodule

//--- hw/cpu_result.sv
`include "cpu_params.svh"

module cpu_result
(
    input  logic             clk,
    input  logic             arst_n,
    input  cpu_pkg::ex_mem_t ex_mem,
    output cpu_pkg::wb_t     wb
);

    localparam int DMEM_AW = $clog2(`CPU_DMEM_WORDS);

    logic [`CPU_XLEN-1:0] dmem [`CPU_DMEM_WORDS];
    logic [DMEM_AW-1:0]   word_idx;
    logic [`CPU_XLEN-1:0] load_data;
    cpu_pkg::wb_t         wb_q;

    assign word_idx  = ex_mem.alu_result[DMEM_AW+1:2]; // wraps on depth
    assign load_data = ex_mem.mem_read ? dmem[word_idx] : '0;

    //////////////////////////////////////////////////
    // word data memory

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int k = 0; k < `CPU_DMEM_WORDS; k++)
                dmem[k] <= '0;
        end
        else if (ex_mem.mem_write)
        begin
            dmem[word_idx] <= ex_mem.store_data;
        end
    end

    // memory to write-back register
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wb_q <= '0;
        end
        else
        begin
            wb_q.valid <= ex_mem.reg_write && (ex_mem.dest != '0);
            wb_q.dest  <= ex_mem.dest;
            wb_q.data  <= ex_mem.mem_to_reg ? load_data : ex_mem.alu_result;
        end
    end

    assign wb = wb_q;

endmodule

//--- hw/cpu_top.sv
`include "cpu_params.svh"

module cpu_top
(
    input  logic                 clk,
    input  logic                 arst_n,
    output logic [`CPU_XLEN-1:0] imem_addr,
    input  cpu_pkg::instr_u      imem_data,
    output cpu_pkg::wb_t         wb
);

    cpu_pkg::id_ex_t  id_ex;
    logic             id_bubble;
    cpu_pkg::ex_mem_t ex_mem;
    cpu_pkg::fwd_t    ex_fwd;
    logic             ex_mem_read;
    cpu_pkg::fwd_t    mem_fwd;

    cpu_decode u_decode
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .ex_fwd      (ex_fwd),
        .ex_mem_read (ex_mem_read),
        .mem_fwd     (mem_fwd),
        .wr          (wb),        // register file write port
        .id_ex       (id_ex),
        .id_bubble   (id_bubble)
    );

    cpu_execute u_execute
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .id_ex       (id_ex),
        .id_bubble   (id_bubble),
        .wb          (wb),
        .ex_mem      (ex_mem),
        .ex_fwd      (ex_fwd),
        .ex_mem_read (ex_mem_read),
        .mem_fwd     (mem_fwd)
    );

    cpu_result u_result
    (
        .clk    (clk),
        .arst_n (arst_n),
        .ex_mem (ex_mem),
        .wb     (wb)
    );

endmodule

//--- tb/cpu_asserts.sv
`include "cpu_params.svh"

module cpu_asserts
(
    input logic                 clk,
    input logic                 arst_n,
    input logic [`CPU_XLEN-1:0] imem_addr,
    input cpu_pkg::wb_t         wb,
    input cpu_pkg::instr_u      dec_instr,
    input logic                 dec_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    logic dec_redirect_op;

    assign dec_redirect_op = dec_valid && ((dec_instr.r.opcode == `CPU_OP_BEQ)
                                        || (dec_instr.r.opcode == `CPU_OP_J));

    //////////////////////////////////////////////////
    // reset state, held through the first cycle out of reset

    reset_quiet: assert property (@(posedge clk)
        (!arst_n || !$past(arst_n)) |-> (!wb.valid && (imem_addr == '0)))
        else $error("write-back or fetch address active around reset");

    //////////////////////////////////////////////////
    // write-back and fetch address sanity

    no_r0_write: assert property (@(posedge clk) disable iff (!arst_n)
        wb.valid |-> (wb.dest != '0))
        else $error("write-back strobe for register 0");

    addr_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        imem_addr[1:0] == 2'b00)
        else $error("fetch address not word aligned");

    // pc only jumps when a beq or j sat in decode the cycle before
    pc_flow: assert property (@(posedge clk) disable iff (!arst_n)
        $past(arst_n) |-> ((imem_addr == $past(imem_addr))
                        || (imem_addr == $past(imem_addr) + 'd4)
                        || $past(dec_redirect_op)))
        else $error("fetch address changed without a branch or jump");

endmodule

bind cpu_top cpu_asserts u_asserts
(
    .clk       (clk),
    .arst_n    (arst_n),
    .imem_addr (imem_addr),
    .wb        (wb),
    .dec_instr (u_decode.instr_q),
    .dec_valid (u_decode.valid_q)
);

//--- tb/cpu_tb.sv
`include "cpu_params.svh"

module cpu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_LEN   = 200;
    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 10;
    localparam int WDOG_CYCLES = RST_CYCLES + PROG_LEN * 4 + 100;
    localparam int EXP_MAX    = 1024;

    logic                 clk;
    logic                 arst_n;
    logic [`CPU_XLEN-1:0] imem_addr;
    cpu_pkg::instr_u      imem_data;
    cpu_pkg::wb_t         wb;

    logic [31:0]          prog [PROG_LEN];
    logic [4:0]           exp_dest [EXP_MAX];
    logic [31:0]          exp_data [EXP_MAX];
    int                   exp_n;
    int                   exp_idx;
    logic [4:0]           head_dest;
    logic [31:0]          head_data;
    int                   dest_errs;
    int                   data_errs;
    int                   other_errs;

    cpu_top UUT
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb        (wb)
    );

    //////////////////////////////////////////////////
    // encoders and program generation

    function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
        return {`CPU_OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(input logic [25:0] target);
        return {`CPU_OP_J, target};
    endfunction

    function automatic logic [4:0] pick_reg();
        return 5'($urandom_range(0, 7)); // short range for many hazards
    endfunction

    task automatic build_program();
        logic [5:0] fns [5];
        int         i;
        int         pick;
        int         span;
        logic [4:0] ra;
        logic [4:0] rb;
        logic [15:0] off;
        begin
            fns = '{`CPU_FN_ADD, `CPU_FN_SUB, `CPU_FN_AND, `CPU_FN_OR, `CPU_FN_SLT};
            i = 0;
            while (i < PROG_LEN)
            begin
                pick = $urandom_range(0, 99);
                span = PROG_LEN - i - 1;
                if (span > 4)
                    span = 4;
                if (pick < 12 && i + 3 <= PROG_LEN)
                begin
                    // store, load back, then use the load at once
                    ra  = 5'($urandom_range(1, 7));
                    rb  = 5'($urandom_range(1, 7));
                    off = 16'($urandom_range(0, 31) * 4);
                    prog[i]     = enc_i(`CPU_OP_SW, 5'd0, ra, off);
                    prog[i + 1] = enc_i(`CPU_OP_LW, 5'd0, rb, off);
                    prog[i + 2] = enc_r(rb, pick_reg(), pick_reg(), `CPU_FN_ADD);
                    i += 3;
                end
                else
                begin
                    if (pick < 40)
                        prog[i] = enc_r(pick_reg(), pick_reg(), pick_reg(),
                                        fns[$urandom_range(0, 4)]);
                    else if (pick < 55)
                        prog[i] = enc_i(`CPU_OP_ADDI, pick_reg(), pick_reg(),
                                        16'($urandom_range(0, 511) - 256));
                    else if (pick < 65)
                        prog[i] = enc_i(`CPU_OP_LW, pick_reg(), pick_reg(),
                                        16'($urandom_range(0, 63) * 4));
                    else if (pick < 75)
                        prog[i] = enc_i(`CPU_OP_SW, pick_reg(), pick_reg(),
                                        16'($urandom_range(0, 63) * 4));
                    else if (pick < 88)
                    begin
                        ra = pick_reg();
                        rb = ($urandom_range(0, 1) == 0) ? ra : pick_reg(); // often taken
                        prog[i] = enc_i(`CPU_OP_BEQ, ra, rb, 16'($urandom_range(0, span)));
                    end
                    else
                        prog[i] = enc_j(26'(i + 1 + $urandom_range(0, span)));
                    i += 1;
                end
            end
        end
    endtask

    //////////////////////////////////////////////////
    // instruction-level model

    task automatic run_model();
        logic [31:0]     regs [32];
        logic [31:0]     dmem [32];
        logic [31:0]     pc;
        logic [31:0]     pc4;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     sx;
        logic [31:0]     res;
        logic [4:0]      dst;
        logic            wr;
        cpu_pkg::instr_u w;
        begin
            for (int k = 0; k < 32; k++)
            begin
                regs[k] = '0;
                dmem[k] = '0;
            end
            exp_n = 0;
            pc    = '0;
            while (pc < PROG_LEN * 4)
            begin
                w   = prog[pc[31:2]];
                pc4 = pc + 4;
                a   = regs[w.i.rs];
                b   = regs[w.i.rt];
                sx  = {{16{w.i.imm[15]}}, w.i.imm};
                wr  = 1'b0;
                dst = w.i.rt;
                res = '0;
                pc  = pc4;
                case (w.r.opcode)
                    `CPU_OP_RTYPE:
                    begin
                        wr  = 1'b1;
                        dst = w.r.rd;
                        case (w.r.funct)
                            `CPU_FN_ADD: res = a + b;
                            `CPU_FN_SUB: res = a - b;
                            `CPU_FN_AND: res = a & b;
                            `CPU_FN_OR:  res = a | b;
                            `CPU_FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                            default:     res = '0;
                        endcase
                    end
                    `CPU_OP_ADDI:
                    begin
                        wr  = 1'b1;
                        res = a + sx;
                    end
                    `CPU_OP_LW:
                    begin
                        wr  = 1'b1;
                        res = dmem[5'((a + sx) >> 2)]; // word index wraps
                    end
                    `CPU_OP_SW:   dmem[5'((a + sx) >> 2)] = b;
                    `CPU_OP_BEQ:
                    begin
                        if (a == b)
                            pc = pc4 + (sx << 2);
                    end
                    `CPU_OP_J:    pc = {pc4[31:28], w.j.target, 2'b00};
                    default:      wr = 1'b0;
                endcase
                if (wr && dst != 5'd0)
                begin
                    regs[dst]       = res;
                    exp_dest[exp_n] = dst;
                    exp_data[exp_n] = res;
                    exp_n++;
                end
            end
        end
    endtask

    //////////////////////////////////////////////////
    // fetch memory with a self-jump past the end

    always_comb
    begin
        if (imem_addr < PROG_LEN * 4)
            imem_data = prog[imem_addr[31:2]];
        else
            imem_data = enc_j(imem_addr[27:2]);
    end

    //////////////////////////////////////////////////
    // write-back checks against the model queue

    assign head_dest = exp_dest[exp_idx];
    assign head_data = exp_data[exp_idx];

    always @(posedge clk)
    begin
        if (arst_n && wb.valid)
            exp_idx <= exp_idx + 1;
    end

    wb_expected: assert property (@(posedge clk) disable iff (!arst_n)
        wb.valid |-> (exp_idx < exp_n))
        else
        begin
            other_errs++;
            $display("write-back at %0t with no expected entry left", $time);
        end

    wb_dest_ok: assert property (@(posedge clk) disable iff (!arst_n)
        (wb.valid && exp_idx < exp_n) |-> (wb.dest == head_dest))
        else
        begin
            dest_errs++;
            $display("mismatch at %0t: wb.dest is %0d, expected %0d",
                     $time, $sampled(wb.dest), $sampled(head_dest));
        end

    wb_data_ok: assert property (@(posedge clk) disable iff (!arst_n)
        (wb.valid && exp_idx < exp_n) |-> (wb.data == head_data))
        else
        begin
            data_errs++;
            $display("mismatch at %0t: wb.data is %h, expected %h",
                     $time, $sampled(wb.data), $sampled(head_data));
        end

    //////////////////////////////////////////////////
    // clock, watchdog, main sequence

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("timeout: program did not complete within %0d cycles", WDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    initial
    begin
        arst_n     = 1'b0;
        exp_idx    = 0;
        dest_errs  = 0;
        data_errs  = 0;
        other_errs = 0;
        void'($urandom(32'h341b));
        build_program();
        run_model();
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        while (!(exp_idx == exp_n && imem_addr >= PROG_LEN * 4))
            @(negedge clk);
        repeat (8) @(posedge clk); // let stray write-backs surface
        @(negedge clk);
        if (exp_idx != exp_n)
        begin
            other_errs++;
            $display("%0d write-backs seen where %0d were expected", exp_idx, exp_n);
        end
        $display("errors: dest %0d, data %0d, other %0d (%0d write-backs checked)",
                 dest_errs, data_errs, other_errs, exp_idx);
        if (dest_errs + data_errs + other_errs == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule
